/* tb.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/bus_pkg.sv
hdl/fifo.sv
hdl/cache_storage.sv
hdl/cache.sv
hdl/miss_arbiter.sv
hdl/line_rom.sv
hdl/dual_cache_top.sv
verif/cache_tb.sv

/* Bender.yml */
package:
  name: dual_cache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/bus_pkg.sv
      - hdl/fifo.sv
      - hdl/cache_storage.sv
      - hdl/cache.sv
      - hdl/miss_arbiter.sv
      - hdl/line_rom.sv
      - hdl/dual_cache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/cache_tb.sv

/* verif/cache_tb.sv */
`default_nettype none
`include "cache_consts.svh"

module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cache_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int RAND_REQ = 100;
	// requests of all tests together
	localparam int TOTAL_REQ = 5 + 4 + 8 + 2 * RAND_REQ;
	localparam logic [`BLK_W-1:0] PATTERN = 8'h5a;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [1:0] us_valid = '0;
	req_t us_req [2] = '{default: '0};
	logic [1:0] us_stall;
	logic [1:0] ds_valid;
	hit_t ds_resp [2];
	logic [1:0] ds_stall = '0;

	// per port stimulus buffers indexed by sideband
	req_t stim [2][256];
	int stim_wr [2] = '{0, 0};
	int stim_rd [2] = '{0, 0};
	// 0 none, 1 held, 2 random
	logic [1:0] stall_mode [2] = '{2'd0, 2'd0};

	// scoreboard indexed by sideband
	logic [`ADDR_W-1:0] sb_addr [2][256];
	logic [255:0] pend [2];
	int accepted [2] = '{0, 0};
	int answered [2] = '{0, 0};
	int stall_cnt [2] = '{0, 0};

	integer seed = 58;
	int errors = 0;
	int tests = 0;
	int issued = 0;
	string test_name = "reset_state";

	dual_cache_top i_dual_cache_top (
		.clk, .rst, .us_valid, .us_req, .us_stall, .ds_valid, .ds_resp, .ds_stall
	);

	initial forever #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			us_valid <= '0;
			ds_stall <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (!us_valid[p] || !us_stall[p]) begin
					if (stim_rd[p] != stim_wr[p]) begin
						us_valid[p] <= 1'b1;
						us_req[p] <= stim[p][stim_rd[p]];
						stim_rd[p] <= stim_rd[p] + 1;
					end else begin
						us_valid[p] <= 1'b0;
					end
				end
				case (stall_mode[p])
					2'd1: ds_stall[p] <= 1'b1;
					2'd2: ds_stall[p] <= (($random(seed) & 3) == 0);
					default: ds_stall[p] <= 1'b0;
				endcase
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			pend[0] <= '0;
			pend[1] <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (us_valid[p] && !us_stall[p]) begin
					sb_addr[p][us_req[p].side] <= us_req[p].addr;
					pend[p][us_req[p].side] <= 1'b1;
					accepted[p] <= accepted[p] + 1;
				end
				if (ds_valid[p] && !ds_stall[p]) begin
					pend[p][ds_resp[p].side] <= 1'b0;
					answered[p] <= answered[p] + 1;
				end
				if (us_valid[p] && us_stall[p])
					stall_cnt[p] <= stall_cnt[p] + 1;
			end
		end
	end

	assert property (@(posedge clk) $fell(rst) |-> ds_valid == 2'b00 && us_stall == 2'b00)
		else begin
			errors++;
			$display("** Error: test %s expected ds_valid=00 us_stall=00, actual %b %b",
				test_name, $sampled(ds_valid), $sampled(us_stall));
		end

	for (genvar p = 0; p < 2; p++) begin : g_check
		assert property (@(posedge clk) disable iff (rst)
			ds_valid[p] && !ds_stall[p] |-> pend[p][ds_resp[p].side])
			else begin
				errors++;
				$display("test %s: port %0d answered sideband %0d that was not outstanding",
					test_name, p, $sampled(ds_resp[p].side));
			end
		assert property (@(posedge clk) disable iff (rst)
			ds_valid[p] && !ds_stall[p] |-> ds_resp[p].data == (sb_addr[p][ds_resp[p].side] ^ PATTERN))
			else begin
				errors++;
				$display("** Error: test %s port %0d side %0d expected %h actual %h", test_name, p,
					$sampled(ds_resp[p].side), sb_addr[p][$sampled(ds_resp[p].side)] ^ PATTERN,
					$sampled(ds_resp[p].data));
			end
		assert property (@(posedge clk) disable iff (rst)
			ds_valid[p] && ds_stall[p] |=> ds_valid[p] && $stable(ds_resp[p]))
			else begin
				errors++;
				$display("test %s: port %0d dropped or changed its response while stalled",
					test_name, p);
			end
	end

	task automatic push_req(input int p, input logic [`ADDR_W-1:0] addr);
		req_t req;
		req.side = stim_wr[p][`SIDE_W-1:0];
		req.addr = addr;
		stim[p][stim_wr[p]] = req;
		stim_wr[p] = stim_wr[p] + 1;
		issued++;
	endtask

	function automatic logic all_done();
		return stim_rd[0] == stim_wr[0] && stim_rd[1] == stim_wr[1] && us_valid == 2'b00
			&& pend[0] == '0 && pend[1] == '0;
	endfunction

	// polls at the falling edge until every request is answered
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (!all_done() && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (all_done())
			else begin
				errors++;
				$display("test %s: requests still outstanding after %0d cycles", test_name, n);
			end
	endtask

	task automatic end_test(input int err_start);
		tests++;
		$display("test %s finished with %0d errors", test_name, errors - err_start);
	endtask

	initial begin
		repeat (RESET_CYCLES + 200 * TOTAL_REQ) @(posedge clk);
		$display("watchdog: run did not finish within the time allowed for its requests");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int err_start;
		int n;
		int snap;
		err_start = errors;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(negedge clk);
		end_test(err_start);

		// merged misses and replays on one cold line
		test_name = "cold_line_burst";
		err_start = errors;
		push_req(0, 8'h20);
		push_req(0, 8'h21);
		push_req(0, 8'h20);
		push_req(0, 8'h21);
		push_req(0, 8'h20);
		wait_idle(200 * 5);
		end_test(err_start);

		test_name = "dual_port_miss";
		err_start = errors;
		push_req(0, 8'h40);
		push_req(1, 8'h62);
		push_req(0, 8'h88);
		push_req(1, 8'h89);
		wait_idle(200 * 4);
		end_test(err_start);

		test_name = "backpressure";
		err_start = errors;
		stall_mode[0] = 2'd1;
		snap = stall_cnt[0];
		for (int i = 0; i < 8; i++)
			push_req(0, 8'h20);
		n = 0;
		while (stall_cnt[0] - snap < 4 && n < 200) begin
			@(negedge clk);
			n++;
		end
		assert (stall_cnt[0] - snap >= 4)
			else begin
				errors++;
				$display("test %s: us_stall never rose while ds_stall was held", test_name);
			end
		stall_mode[0] = 2'd0;
		wait_idle(200 * 8);
		end_test(err_start);

		test_name = "random_traffic";
		err_start = errors;
		stall_mode[0] = 2'd2;
		stall_mode[1] = 2'd2;
		for (int i = 0; i < RAND_REQ; i++) begin
			push_req(0, 8'($random(seed)) & 8'h3f);
			push_req(1, 8'($random(seed)) & 8'h3f);
		end
		wait_idle(200 * 2 * RAND_REQ);
		stall_mode[0] = 2'd0;
		stall_mode[1] = 2'd0;
		for (int p = 0; p < 2; p++) begin
			assert (pend[p] == '0 && answered[p] == accepted[p])
				else begin
					errors++;
					$display("test %s: port %0d answered %0d of %0d accepted requests",
						test_name, p, answered[p], accepted[p]);
				end
		end
		end_test(err_start);

		$display("tests %0d, issued %0d, accepted %0d, answered %0d, errors %0d", tests, issued,
			accepted[0] + accepted[1], answered[0] + answered[1], errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/dual_cache_top.sv */
`default_nettype none

module dual_cache_top (
	input  logic clk,
	input  logic rst,
	input  logic [1:0] us_valid,
	input  cache_pkg::req_t us_req [2],
	output logic [1:0] us_stall,
	output logic [1:0] ds_valid,
	output cache_pkg::hit_t ds_resp [2],
	input  logic [1:0] ds_stall
);
	import bus_pkg::*;

	logic [1:0] miss_valid;
	line_addr_t miss_addr [2];
	logic [1:0] miss_ready;
	logic [1:0] fill_valid;
	fill_t fill;
	logic [1:0] fill_ready;

	// line memory bus
	logic arvalid;
	logic arready;
	axil_ar_t ar;
	logic rvalid;
	logic rready;
	axil_r_t r;

	for (genvar i = 0; i < 2; i++) begin : g_cache
		cache i_cache (
			.clk, .rst,
			.us_valid(us_valid[i]),
			.us_req(us_req[i]),
			.us_stall(us_stall[i]),
			.ds_valid(ds_valid[i]),
			.ds_resp(ds_resp[i]),
			.ds_stall(ds_stall[i]),
			.miss_valid(miss_valid[i]),
			.miss_addr(miss_addr[i]),
			.miss_ready(miss_ready[i]),
			.fill_valid(fill_valid[i]),
			.fill(fill),
			.fill_ready(fill_ready[i])
		);
	end

	miss_arbiter i_arbiter (
		.clk, .rst,
		.miss_valid, .miss_addr, .miss_ready,
		.fill_valid, .fill, .fill_ready,
		.arvalid, .ar, .arready,
		.rvalid, .r, .rready
	);

	line_rom i_rom (
		.clk, .rst,
		.arvalid, .ar, .arready,
		.rvalid, .r, .rready
	);

endmodule

`default_nettype wire

/* hdl/line_rom.sv */
`default_nettype none
`include "cache_consts.svh"

module line_rom (
	input  logic clk,
	input  logic rst,
	input  logic arvalid,
	input  bus_pkg::axil_ar_t ar,
	output logic arready,
	output logic rvalid,
	output bus_pkg::axil_r_t r,
	input  logic rready
);
	import bus_pkg::*;

	localparam int NUM_BLK = `LINE_W / `BLK_W;
	localparam logic [`BLK_W-1:0] PATTERN = 8'h5a;

	line_addr_t line_q;

	// one read at a time
	assign arready = ~rvalid;

	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready)
			line_q <= ar.addr[`ADDR_W-1:`BO_W];
	end

	// each byte is its own address xor the pattern
	always_comb begin
		r.resp = AXI_RESP_OKAY;
		for (int b = 0; b < NUM_BLK; b++)
			r.data[b*`BLK_W +: `BLK_W] = {line_q, `BO_W'(b)} ^ PATTERN;
	end

endmodule

`default_nettype wire

/* hdl/miss_arbiter.sv */
`default_nettype none
`include "cache_consts.svh"

module miss_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic [1:0] miss_valid,
	input  bus_pkg::line_addr_t miss_addr [2],
	output logic [1:0] miss_ready,
	output logic [1:0] fill_valid,
	output bus_pkg::fill_t fill,
	input  logic [1:0] fill_ready,
	output logic arvalid,
	output bus_pkg::axil_ar_t ar,
	input  logic arready,
	input  logic rvalid,
	input  bus_pkg::axil_r_t r,
	output logic rready
);
	import bus_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR, DATA, FILL} state_t;

	state_t state;
	// one-hot grant held after the fill as the last winner
	logic [1:0] gnt;
	logic [1:0] pick;
	line_addr_t line_q;

	// alternate when both caches ask
	assign pick = (miss_valid == 2'b11) ? {gnt[0], gnt[1]} : miss_valid;
	assign miss_ready = (state == IDLE) ? pick : 2'b00;

	// unprivileged secure data access
	assign ar = '{addr: {line_q, {`BO_W{1'b0}}}, prot: 3'b000};
	assign arvalid = (state == ADDR);
	assign rready = (state == DATA);
	assign fill_valid = (state == FILL) ? gnt : 2'b00;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			gnt <= 2'b10;
		end else begin
			case (state)
				IDLE: if (|miss_valid) begin
					state <= ADDR;
					gnt <= pick;
				end
				ADDR: if (arready)
					state <= DATA;
				DATA: if (rvalid)
					state <= FILL;
				FILL: if (|(fill_ready & gnt))
					state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE)
			line_q <= miss_addr[pick[1]];
		if (state == DATA && rvalid)
			fill <= fill_t'(r.data);
	end

	assert property (@(posedge clk) disable iff (rst) $onehot(gnt))
		else $error("miss_arbiter: grant not one-hot");

endmodule

`default_nettype wire

/* hdl/cache.sv */
`default_nettype none
`include "cache_consts.svh"

module cache (
	input  logic clk,
	input  logic rst,
	input  logic us_valid,
	input  cache_pkg::req_t us_req,
	output logic us_stall,
	output logic ds_valid,
	output cache_pkg::hit_t ds_resp,
	input  logic ds_stall,
	output logic miss_valid,
	output bus_pkg::line_addr_t miss_addr,
	input  logic miss_ready,
	input  logic fill_valid,
	input  bus_pkg::fill_t fill,
	output logic fill_ready
);
	import cache_pkg::*;
	import bus_pkg::*;

	localparam int CNT_W = $clog2(`RIF_DEPTH + 1);

	// request stage
	logic stage_valid;
	req_t stage_req;
	logic stage_stall;
	logic stage_ready;
	logic stage_miss;
	logic us_take;
	req_t replay_req;
	line_addr_t stage_line;

	logic [`ADDR_W-1:0] raddr;
	logic [`BLK_W-1:0] rdata;
	logic hit;

	hit_t hdf_in;
	logic hdf_we;
	logic hdf_full;
	logic hdf_empty;
	logic mrf_we;
	logic mrf_empty;
	logic in_mrf;
	reissue_t rifb_in;
	reissue_t rifb_out;
	logic rifb_re;
	logic rifb_full;
	logic rifb_empty;
	reissue_t rif_out;
	logic rif_re;
	logic rif_full;
	logic rif_empty;

	// requests in stage, reissue buffer and reissue queue
	logic [CNT_W-1:0] in_flight;

	assign stage_line = stage_req.addr[`ADDR_W-1:`BO_W];
	assign stage_stall = stage_valid & (hit ? hdf_full : rifb_full);
	assign stage_ready = ~stage_stall;
	assign stage_miss = stage_valid & stage_ready & ~hit;

	// replays go first, a flagged one only together with its fill
	assign rif_re = ~rif_empty & stage_ready & (~rif_out.wait_fill | fill_valid);
	assign fill_ready = rif_re & rif_out.wait_fill;
	assign replay_req = '{side: rif_out.side, addr: rif_out.addr};

	// in_flight limit keeps every miss room in the reissue queue
	assign us_stall = rif_re | stage_stall | (in_flight == CNT_W'(`RIF_DEPTH));
	assign us_take = us_valid & ~us_stall;

	// a stalled stage reads its own address again
	assign raddr = stage_stall ? stage_req.addr : (rif_re ? rif_out.addr : us_req.addr);

	assign hdf_in = '{data: rdata, side: stage_req.side};
	assign hdf_we = stage_valid & stage_ready & hit;
	assign ds_valid = ~hdf_empty;

	// one outstanding miss request per line
	assign mrf_we = stage_miss & ~in_mrf;
	assign miss_valid = ~mrf_empty;

	assign rifb_in = '{addr: stage_req.addr, side: stage_req.side, wait_fill: ~in_mrf};
	assign rifb_re = ~rifb_empty & ~rif_full;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= 1'b0;
			in_flight <= '0;
		end else begin
			if (stage_ready)
				stage_valid <= rif_re | us_take;
			in_flight <= in_flight + CNT_W'(us_take) - CNT_W'(hdf_we);
		end
	end

	always_ff @(posedge clk) begin
		if (rif_re)
			stage_req <= replay_req;
		else if (us_take)
			stage_req <= us_req;
	end

	cache_storage i_storage (
		.clk, .rst,
		.raddr(raddr),
		.waddr(rif_out.addr),
		.wdata(fill),
		.we(fill_ready),
		.pipe_tag(stage_req.addr[`ADDR_W-1:`ADDR_W-`TAG_W]),
		.pipe_bo(stage_req.addr[`BO_W-1:0]),
		.rdata(rdata),
		.hit(hit)
	);

	fifo #(.T(hit_t), .DEPTH(`FIFO_DEPTH)) i_hdf (
		.clk, .rst,
		.data_in(hdf_in), .we(hdf_we), .re(~ds_stall & ~hdf_empty),
		.full(hdf_full), .empty(hdf_empty), .data_out(ds_resp),
		.num_left(), .match_key('0), .exists()
	);

	fifo #(.T(line_addr_t), .DEPTH(`RIF_DEPTH)) i_mrf (
		.clk, .rst,
		.data_in(stage_line), .we(mrf_we), .re(miss_valid & miss_ready),
		.full(), .empty(mrf_empty), .data_out(miss_addr),
		.num_left(), .match_key(stage_line), .exists(in_mrf)
	);

	fifo #(.T(reissue_t), .DEPTH(`FIFO_DEPTH)) i_rifb (
		.clk, .rst,
		.data_in(rifb_in), .we(stage_miss), .re(rifb_re),
		.full(rifb_full), .empty(rifb_empty), .data_out(rifb_out),
		.num_left(), .match_key('0), .exists()
	);

	fifo #(.T(reissue_t), .DEPTH(`RIF_DEPTH)) i_rif (
		.clk, .rst,
		.data_in(rifb_out), .we(rifb_re), .re(rif_re),
		.full(rif_full), .empty(rif_empty), .data_out(rif_out),
		.num_left(), .match_key('0), .exists()
	);

endmodule

`default_nettype wire

/* hdl/cache_storage.sv */
`default_nettype none
`include "cache_consts.svh"

module cache_storage (
	input  logic clk,
	input  logic rst,
	input  logic [`ADDR_W-1:0] raddr,
	input  logic [`ADDR_W-1:0] waddr,
	input  bus_pkg::fill_t wdata,
	input  logic we,
	input  logic [`TAG_W-1:0] pipe_tag,
	input  logic [`BO_W-1:0] pipe_bo,
	output logic [`BLK_W-1:0] rdata,
	output logic hit
);
	import bus_pkg::*;

	localparam int NUM_SETS = 1 << `INDEX_W;

	fill_t way0 [NUM_SETS];
	fill_t way1 [NUM_SETS];
	logic [`TAG_W-1:0] tag0 [NUM_SETS];
	logic [`TAG_W-1:0] tag1 [NUM_SETS];
	logic [NUM_SETS-1:0] valid0;
	logic [NUM_SETS-1:0] valid1;
	logic way_sel;

	logic [`INDEX_W-1:0] rd_index;
	logic [`INDEX_W-1:0] wr_index;
	logic [`TAG_W-1:0] wr_tag;

	// registered lookup
	fill_t line0_q;
	fill_t line1_q;
	fill_t wline_q;
	logic [`TAG_W-1:0] tag0_q;
	logic [`TAG_W-1:0] tag1_q;
	logic valid0_q;
	logic valid1_q;
	logic wr_q;
	logic hit0;
	logic hit1;
	fill_t line;

	assign rd_index = raddr[`INDEX_W+`BO_W-1:`BO_W];
	assign wr_index = waddr[`INDEX_W+`BO_W-1:`BO_W];
	assign wr_tag = waddr[`ADDR_W-1:`ADDR_W-`TAG_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			way_sel <= 1'b0;
			valid0 <= '0;
			valid1 <= '0;
			valid0_q <= 1'b0;
			valid1_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			wr_q <= we;
			valid0_q <= valid0[rd_index];
			valid1_q <= valid1[rd_index];
			if (we) begin
				way_sel <= ~way_sel;
				// a refill of a resident line keeps only the new copy
				if (way_sel) begin
					valid1[wr_index] <= 1'b1;
					if (tag0[wr_index] == wr_tag)
						valid0[wr_index] <= 1'b0;
				end else begin
					valid0[wr_index] <= 1'b1;
					if (tag1[wr_index] == wr_tag)
						valid1[wr_index] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we && way_sel) begin
			way1[wr_index] <= wdata;
			tag1[wr_index] <= wr_tag;
		end
		if (we && !way_sel) begin
			way0[wr_index] <= wdata;
			tag0[wr_index] <= wr_tag;
		end
		line0_q <= way0[rd_index];
		line1_q <= way1[rd_index];
		tag0_q <= tag0[rd_index];
		tag1_q <= tag1[rd_index];
		wline_q <= wdata;
	end

	assign hit0 = valid0_q & (tag0_q == pipe_tag);
	assign hit1 = valid1_q & (tag1_q == pipe_tag);
	// line written in the lookup cycle is a hit
	assign hit = wr_q | hit0 | hit1;
	assign line = wr_q ? wline_q : (hit1 ? line1_q : line0_q);
	assign rdata = line.blk[pipe_bo];

	// one copy per line across fills
	assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1))
		else $error("cache_storage: both ways hit");

endmodule

`default_nettype wire

/* hdl/fifo.sv */
`default_nettype none

module fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  T data_in,
	input  logic we,
	input  logic re,
	output logic full,
	output logic empty,
	output T data_out,
	output logic [$clog2(DEPTH+1)-1:0] num_left,
	input  T match_key,
	output logic exists
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [DEPTH-1:0] vld;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_we;
	logic do_re;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign num_left = CNT_W'(DEPTH) - count;
	assign do_we = we & ~full;
	assign do_re = re & ~empty;
	// show-ahead
	assign data_out = mem[rd_ptr];

	// any live entry equal to the key
	always_comb begin
		exists = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (vld[i] && (mem[i] == match_key))
				exists = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			vld <= '0;
		end else begin
			if (do_re) begin
				rd_ptr <= next_ptr(rd_ptr);
				vld[rd_ptr] <= 1'b0;
			end
			if (do_we) begin
				wr_ptr <= next_ptr(wr_ptr);
				vld[wr_ptr] <= 1'b1;
			end
			count <= count + CNT_W'(do_we) - CNT_W'(do_re);
		end
	end

	always_ff @(posedge clk) begin
		if (do_we)
			mem[wr_ptr] <= data_in;
	end

	assert property (@(posedge clk) disable iff (rst) we |-> !full)
		else $error("fifo: write while full");
	assert property (@(posedge clk) disable iff (rst) re |-> !empty)
		else $error("fifo: read while empty");

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none
`include "cache_consts.svh"

package bus_pkg;

	// tag and index of one line
	typedef logic [`TAG_W+`INDEX_W-1:0] line_addr_t;

	// block 0 sits in the low byte
	typedef struct packed {
		logic [(1<<`BO_W)-1:0][`BLK_W-1:0] blk;
	} fill_t;

	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [2:0] prot;
	} axil_ar_t;

	typedef struct packed {
		logic [`LINE_W-1:0] data;
		logic [1:0] resp;
	} axil_r_t;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* hdl/cache_pkg.sv */
`default_nettype none
`include "cache_consts.svh"

package cache_pkg;

	// request as held in the request stage
	typedef struct packed {
		logic [`SIDE_W-1:0] side;
		logic [`ADDR_W-1:0] addr;
	} req_t;

	// response toward downstream
	typedef struct packed {
		logic [`BLK_W-1:0] data;
		logic [`SIDE_W-1:0] side;
	} hit_t;

	// replay entry, wait_fill set on the entry that issued the miss
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`SIDE_W-1:0] side;
		logic wait_fill;
	} reissue_t;

endpackage

`default_nettype wire

/* hdl/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address is tag, then index, then block offset
`define ADDR_W 8
`define TAG_W 3
`define INDEX_W 4
`define BO_W 1

// byte, two-byte line and request sideband
`define BLK_W 8
`define LINE_W 16
`define SIDE_W 8

// queue depths
`define FIFO_DEPTH 4
`define RIF_DEPTH 6

`endif
